/* all.f */
+incdir+verilog
verilog/soc_pkg.sv
verilog/bus_host_port.sv
verilog/periph_ram.sv
verilog/periph_gpio.sv
verilog/periph_timer.sv
verilog/bus_rsp_port.sv
verilog/periph_soc_top.sv
verif/periph_soc_assertions.sv
verif/periph_soc_tb.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f \
  --top-module periph_soc_tb -Mdir obj_dir -o periph_soc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed"
  exit $status
fi

./obj_dir/periph_soc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed"
  exit $status
fi

exit 0

/* verif/periph_soc_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module periph_soc_tb import soc_pkg::*; ();

  localparam int READY_TIMEOUT = 20;
  localparam int RSP_TIMEOUT   = 20;
  localparam int IRQ_TIMEOUT   = 100;

  logic     clk_sys;
  logic     rst_n;
  logic     req_valid;
  logic     req_ready;
  bus_req_t req;
  logic     rsp_valid;
  logic     rsp_ready;
  bus_rsp_t rsp;
  gpi_t     gp_in;
  gpo_t     gp_out;
  logic     timer_irq;

  bus_req_t tbl_req [$];
  bus_rsp_t tbl_rsp [$];
  logic     tbl_chk [$];
  int       seed = 91;
  int       rsp_count;
  int       access_count = 0;

  periph_soc_top DUT (
    .clk_sys_i  (clk_sys),
    .rst_n_i    (rst_n),
    .req_valid_i(req_valid),
    .req_ready_o(req_ready),
    .req_i      (req),
    .rsp_valid_o(rsp_valid),
    .rsp_ready_i(rsp_ready),
    .rsp_o      (rsp),
    .gp_i       (gp_in),
    .gp_o       (gp_out),
    .timer_irq_o(timer_irq)
  );

  initial begin
    clk_sys = 1'b0;
    forever #4 clk_sys = ~clk_sys;
  end

  // Completed response handshakes.
  always @(posedge clk_sys or negedge rst_n) begin
    if (!rst_n) begin
      rsp_count <= 0;
    end else if (rsp_valid && rsp_ready) begin
      rsp_count <= rsp_count + 1;
    end
  end

  ////////////////////
  // Checks
  ////////////////////

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_rsp(input bus_rsp_t got, input bus_rsp_t exp, input logic cmp_data);
    if (cmp_data && got !== exp) begin
      $display("FAIL rsp_o got %h expected %h", got, exp);
      fail_stop("response mismatch");
    end else if (got.err !== exp.err) begin
      $display("FAIL rsp_o.err got %h expected %h", got.err, exp.err);
      fail_stop("response error flag mismatch");
    end
  endtask

  task automatic check_gpo(input gpo_t got, input gpo_t exp);
    if (got !== exp) begin
      $display("FAIL gp_o got %h expected %h", got, exp);
      fail_stop("gpio output mismatch");
    end
  endtask

  task automatic check_irq(input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL timer_irq_o got %h expected %h", got, exp);
      fail_stop("timer interrupt mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      fail_stop("handshake signal mismatch");
    end
  endtask

  ////////////////////
  // Stimulus
  ////////////////////

  function automatic bus_req_t make_req(addr_t a, logic we, be_t be, data_t wd);
    return '{addr: a, we: we, be: be, wdata: wd};
  endfunction

  function automatic bus_rsp_t make_rsp(data_t rd, logic err);
    return '{rdata: rd, err: err};
  endfunction

  task automatic add_entry(input addr_t a, input logic we, input be_t be, input data_t wd,
                           input data_t rd, input logic err, input logic chk);
    tbl_req.push_back(make_req(a, we, be, wd));
    tbl_rsp.push_back(make_rsp(rd, err));
    tbl_chk.push_back(chk);
  endtask

  // Entered and left on a falling edge.
  task automatic do_access(input bus_req_t r, input bus_rsp_t exp, input logic chk);
    int waited;
    int delay;
    req       = r;
    req_valid = 1'b1;
    waited    = 0;
    while (!req_ready) begin
      if (waited == READY_TIMEOUT) begin
        fail_stop("timeout waiting for the request to be accepted");
      end
      waited++;
      @(negedge clk_sys);
    end
    @(negedge clk_sys);
    req_valid = 1'b0;
    waited    = 0;
    while (!rsp_valid) begin
      if (waited == RSP_TIMEOUT) begin
        fail_stop("timeout waiting for a response");
      end
      waited++;
      @(negedge clk_sys);
    end
    delay = $random(seed) & 3;
    repeat (delay) @(negedge clk_sys);
    check_flag("rsp_valid_o", rsp_valid, 1'b1);
    check_rsp(rsp, exp, chk);
    rsp_ready = 1'b1;
    @(negedge clk_sys);
    rsp_ready = 1'b0;
    access_count++;
    check_flag("rsp_valid_o", rsp_valid, 1'b0);
    if (rsp_count != access_count) begin
      fail_stop("number of responses differs from number of accesses");
    end
  endtask

  task automatic wait_irq_high();
    int waited;
    waited = 0;
    while (!timer_irq) begin
      if (waited == IRQ_TIMEOUT) begin
        fail_stop("timeout waiting for the timer interrupt");
      end
      waited++;
      @(negedge clk_sys);
    end
  endtask

  task automatic build_table();
    // addr, we, be, wdata, expected rdata, expected err, compare rdata.
    add_entry(32'h0000_0000, 1'b1, 4'b1111, 32'h1122_3344, 32'h0, 1'b0, 1'b1);
    add_entry(32'h0000_0004, 1'b1, 4'b1111, 32'h5566_7788, 32'h0, 1'b0, 1'b1);
    add_entry(32'h0000_03FC, 1'b1, 4'b1111, 32'hDEAD_BEEF, 32'h0, 1'b0, 1'b1);
    add_entry(32'h0000_0000, 1'b1, 4'b0101, 32'hAABB_CCDD, 32'h0, 1'b0, 1'b1);
    add_entry(32'h0000_0004, 1'b1, 4'b1000, 32'h99FF_FFFF, 32'h0, 1'b0, 1'b1);
    add_entry(32'h0000_03FC, 1'b1, 4'b0110, 32'h0012_3400, 32'h0, 1'b0, 1'b1);
    add_entry(32'h0000_0000, 1'b0, 4'b1111, 32'h0, 32'h11BB_33DD, 1'b0, 1'b1);
    add_entry(32'h0000_0004, 1'b0, 4'b1111, 32'h0, 32'h9966_7788, 1'b0, 1'b1);
    add_entry(32'h0000_03FC, 1'b0, 4'b1111, 32'h0, 32'hDE12_34EF, 1'b0, 1'b1);
    // GPIO output through the low byte enables.
    add_entry(32'h8000_0000, 1'b1, 4'b0011, 32'h1234_A5C3, 32'h0, 1'b0, 1'b1);
    add_entry(32'h8000_0000, 1'b1, 4'b0010, 32'h0000_5A00, 32'h0, 1'b0, 1'b1);
    add_entry(32'h8000_0000, 1'b0, 4'b1111, 32'h0, 32'h0000_5AC3, 1'b0, 1'b1);
    add_entry(32'h8000_0008, 1'b0, 4'b1111, 32'h0, 32'h0, 1'b0, 1'b1);
    // Timer registers with a free-running mtime.
    add_entry(32'h8000_1004, 1'b0, 4'b1111, 32'h0, 32'hFFFF_FFFF, 1'b0, 1'b1);
    add_entry(32'h8000_1000, 1'b0, 4'b1111, 32'h0, 32'h0, 1'b0, 1'b0);
    // Unmapped window followed by a RAM read.
    add_entry(32'h4000_0000, 1'b0, 4'b1111, 32'h0, 32'h0, 1'b1, 1'b1);
    add_entry(32'h4000_0000, 1'b1, 4'b1111, 32'hFFFF_FFFF, 32'h0, 1'b1, 1'b1);
    add_entry(32'h0000_0000, 1'b0, 4'b1111, 32'h0, 32'h11BB_33DD, 1'b0, 1'b1);
  endtask

  initial begin
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    rsp_ready = 1'b0;
    gp_in     = '0;
    repeat (5) @(posedge clk_sys);
    @(negedge clk_sys);
    rst_n = 1'b1;
    @(negedge clk_sys);
    check_flag("req_ready_o", req_ready, 1'b1);
    check_flag("rsp_valid_o", rsp_valid, 1'b0);
    check_gpo(gp_out, '0);
    check_irq(timer_irq, 1'b0);

    build_table();
    for (int i = 0; i < tbl_req.size(); i++) begin
      do_access(tbl_req[i], tbl_rsp[i], tbl_chk[i]);
    end
    check_gpo(gp_out, 16'h5AC3);

    // GPIO input after the synchronizer settles.
    gp_in = 8'hA7;
    repeat (4) @(negedge clk_sys);
    do_access(make_req(32'h8000_0004, 1'b0, 4'hF, 32'h0), make_rsp(32'h0000_00A7, 1'b0), 1'b1);

    // Timer compare and interrupt.
    do_access(make_req(32'h8000_1004, 1'b1, 4'hF, 32'hFFFF_FFFF), make_rsp(32'h0, 1'b0), 1'b1);
    repeat (3) @(negedge clk_sys);
    check_irq(timer_irq, 1'b0);
    do_access(make_req(32'h8000_1000, 1'b1, 4'hF, 32'h0), make_rsp(32'h0, 1'b0), 1'b1);
    check_irq(timer_irq, 1'b0);
    do_access(make_req(32'h8000_1004, 1'b1, 4'hF, 32'd20), make_rsp(32'h0, 1'b0), 1'b1);
    wait_irq_high();
    check_irq(timer_irq, 1'b1);
    do_access(make_req(32'h8000_1004, 1'b1, 4'hF, 32'hFFFF_FFFF), make_rsp(32'h0, 1'b0), 1'b1);
    @(negedge clk_sys);
    check_irq(timer_irq, 1'b0);

    if (rsp_count == access_count) begin
      $display("TB PASSED");
      $finish;
    end else begin
      fail_stop("final response count does not match the access count");
    end
  end

endmodule

`default_nettype wire

/* verif/periph_soc_assertions.sv */
`timescale 1ns/100ps
`default_nettype none

module periph_soc_assertions import soc_pkg::*; (
  input wire logic        clk_sys_i,
  input wire logic        rst_n_i,
  input wire logic        req_valid_i,
  input wire logic        req_ready_o,
  input wire dev_strobe_t dev_strobe_i,
  input wire logic        rsp_valid_o,
  input wire logic        rsp_ready_i,
  input wire bus_rsp_t    rsp_o
);

  logic accept;

  assign accept = req_valid_i & req_ready_o;

  // At most one device selected per cycle.
  strobe_onehot: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    $onehot0(dev_strobe_i))
    else $error("device strobe has more than one bit set");

  // Response holds while the host stalls.
  rsp_hold: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)))
    else $error("response changed under back-pressure");

  // Fixed two-cycle latency from acceptance to response.
  rsp_latency: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    $rose(rsp_valid_o) |-> $past(accept, 3))
    else $error("response valid without acceptance two cycles earlier");

  accept_latency: assert property (@(posedge clk_sys_i) disable iff (!rst_n_i)
    $past(accept, 3) |-> $rose(rsp_valid_o))
    else $error("accepted request got no response two cycles later");

endmodule

// Checker on the request and response handshakes.
bind periph_soc_top periph_soc_assertions u_assertions (
  .clk_sys_i   (clk_sys_i),
  .rst_n_i     (rst_n_i),
  .req_valid_i (req_valid_i),
  .req_ready_o (req_ready_o),
  .dev_strobe_i(dev_strobe),
  .rsp_valid_o (rsp_valid_o),
  .rsp_ready_i (rsp_ready_i),
  .rsp_o       (rsp_o)
);

`default_nettype wire

/* verilog/periph_soc_top.sv */
`timescale 1ns/100ps
`default_nettype none

module periph_soc_top import soc_pkg::*; (
  input  wire logic     clk_sys_i,
  input  wire logic     rst_n_i,
  input  wire logic     req_valid_i,
  output logic          req_ready_o,
  input  wire bus_req_t req_i,
  output logic          rsp_valid_o,
  input  wire logic     rsp_ready_i,
  output bus_rsp_t      rsp_o,
  input  wire gpi_t     gp_i,
  output gpo_t          gp_o,
  output logic          timer_irq_o
);

  bus_req_t    dev_req;
  dev_strobe_t dev_strobe;
  dev_rsp_t    ram_rsp;
  dev_rsp_t    gpio_rsp;
  dev_rsp_t    timer_rsp;
  logic        decode_err;
  logic        rsp_done;

  ////////////////////
  // Request side
  ////////////////////

  bus_host_port u_host_port (
    .clk_sys_i   (clk_sys_i),
    .rst_n_i     (rst_n_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .req_i       (req_i),
    .dev_req_o   (dev_req),
    .dev_strobe_o(dev_strobe),
    .decode_err_o(decode_err),
    .rsp_done_i  (rsp_done)
  );

  ////////////////////
  // Devices
  ////////////////////

  periph_ram u_ram (
    .clk_sys_i(clk_sys_i),
    .req_i    (dev_req),
    .strobe_i (dev_strobe.ram),
    .rsp_o    (ram_rsp)
  );

  periph_gpio u_gpio (
    .clk_sys_i(clk_sys_i),
    .rst_n_i  (rst_n_i),
    .req_i    (dev_req),
    .strobe_i (dev_strobe.gpio),
    .rsp_o    (gpio_rsp),
    .gp_i     (gp_i),
    .gp_o     (gp_o)
  );

  periph_timer u_timer (
    .clk_sys_i  (clk_sys_i),
    .rst_n_i    (rst_n_i),
    .req_i      (dev_req),
    .strobe_i   (dev_strobe.timer),
    .rsp_o      (timer_rsp),
    .timer_irq_o(timer_irq_o)
  );

  // Response side.
  bus_rsp_port u_rsp_port (
    .clk_sys_i   (clk_sys_i),
    .rst_n_i     (rst_n_i),
    .ram_rsp_i   (ram_rsp),
    .gpio_rsp_i  (gpio_rsp),
    .timer_rsp_i (timer_rsp),
    .decode_err_i(decode_err),
    .rsp_done_o  (rsp_done),
    .rsp_valid_o (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_o       (rsp_o)
  );

endmodule

`default_nettype wire

/* verilog/bus_rsp_port.sv */
`timescale 1ns/100ps
`default_nettype none

module bus_rsp_port import soc_pkg::*; (
  input  wire logic     clk_sys_i,
  input  wire logic     rst_n_i,
  input  wire dev_rsp_t ram_rsp_i,
  input  wire dev_rsp_t gpio_rsp_i,
  input  wire dev_rsp_t timer_rsp_i,
  input  wire logic     decode_err_i,
  output logic          rsp_done_o,
  output logic          rsp_valid_o,
  input  wire logic     rsp_ready_i,
  output bus_rsp_t      rsp_o
);

  logic  any_valid;
  data_t rdata_d;

  assign any_valid = ram_rsp_i.rvalid | gpio_rsp_i.rvalid | timer_rsp_i.rvalid | decode_err_i;

  // At most one source is valid at a time.
  always_comb begin
    rdata_d = '0;
    if (ram_rsp_i.rvalid) begin
      rdata_d = rdata_d | ram_rsp_i.rdata;
    end
    if (gpio_rsp_i.rvalid) begin
      rdata_d = rdata_d | gpio_rsp_i.rdata;
    end
    if (timer_rsp_i.rvalid) begin
      rdata_d = rdata_d | timer_rsp_i.rdata;
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_valid_o <= 1'b0;
      rsp_done_o  <= 1'b0;
    end else begin
      rsp_done_o <= rsp_valid_o & rsp_ready_i;
      if (any_valid) begin
        rsp_valid_o <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_o <= 1'b0;
      end
    end
  end

  // Holding register stays stable until the handshake.
  always_ff @(posedge clk_sys_i) begin
    if (any_valid) begin
      rsp_o <= '{rdata: decode_err_i ? '0 : rdata_d, err: decode_err_i};
    end
  end

endmodule

`default_nettype wire

/* verilog/periph_timer.sv */
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module periph_timer import soc_pkg::*; (
  input  wire logic     clk_sys_i,
  input  wire logic     rst_n_i,
  input  wire bus_req_t req_i,
  input  wire logic     strobe_i,
  output dev_rsp_t      rsp_o,
  output logic          timer_irq_o
);

  data_t mtime_q;
  data_t mtimecmp_q;
  addr_t ofs;
  logic  wr_mtime;
  logic  wr_cmp;
  data_t rdata_d;
  logic  rvalid_q;
  data_t rdata_q;

  assign ofs      = req_i.addr & addr_t'(`SOC_TIMER_MASK);
  assign wr_mtime = strobe_i & req_i.we & (ofs == addr_t'(`SOC_TIMER_MTIME_OFS));
  assign wr_cmp   = strobe_i & req_i.we & (ofs == addr_t'(`SOC_TIMER_CMP_OFS));

  always_comb begin
    rdata_d = '0;
    if (ofs == addr_t'(`SOC_TIMER_MTIME_OFS)) begin
      rdata_d = mtime_q;
    end else if (ofs == addr_t'(`SOC_TIMER_CMP_OFS)) begin
      rdata_d = mtimecmp_q;
    end
  end

  ////////////////////
  // Counter and compare
  ////////////////////

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtime_q     <= '0;
      mtimecmp_q  <= '1;
      timer_irq_o <= 1'b0;
      rvalid_q    <= 1'b0;
    end else begin
      // A bus write wins over the increment.
      if (wr_mtime) begin
        mtime_q <= be_merge(mtime_q, req_i.wdata, req_i.be);
      end else begin
        mtime_q <= mtime_q + data_t'(1);
      end
      if (wr_cmp) begin
        mtimecmp_q <= be_merge(mtimecmp_q, req_i.wdata, req_i.be);
      end
      // Level interrupt.
      timer_irq_o <= (mtime_q >= mtimecmp_q);
      rvalid_q    <= strobe_i;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (strobe_i) begin
      rdata_q <= req_i.we ? '0 : rdata_d;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* verilog/periph_gpio.sv */
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module periph_gpio import soc_pkg::*; (
  input  wire logic     clk_sys_i,
  input  wire logic     rst_n_i,
  input  wire bus_req_t req_i,
  input  wire logic     strobe_i,
  output dev_rsp_t      rsp_o,
  input  wire gpi_t     gp_i,
  output gpo_t          gp_o
);

  gpo_t  gpo_q;
  gpi_t  gpi_meta;
  gpi_t  gpi_sync;
  addr_t ofs;
  data_t rdata_d;
  logic  rvalid_q;
  data_t rdata_q;

  assign ofs  = req_i.addr & addr_t'(`SOC_GPIO_MASK);
  assign gp_o = gpo_q;

  // Read mux by register offset.
  always_comb begin
    rdata_d = '0;
    if (ofs == addr_t'(`SOC_GPIO_OUT_OFS)) begin
      rdata_d = data_t'(gpo_q);
    end else if (ofs == addr_t'(`SOC_GPIO_IN_OFS)) begin
      rdata_d = data_t'(gpi_sync);
    end
  end

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      gpo_q    <= '0;
      gpi_meta <= '0;
      gpi_sync <= '0;
      rvalid_q <= 1'b0;
    end else begin
      // Two-flop synchronizer on the pins.
      gpi_meta <= gp_i;
      gpi_sync <= gpi_meta;
      rvalid_q <= strobe_i;
      if (strobe_i && req_i.we && ofs == addr_t'(`SOC_GPIO_OUT_OFS)) begin
        // Only the low half word exists.
        gpo_q <= gpo_t'(be_merge(data_t'(gpo_q), req_i.wdata, req_i.be & be_t'(2'b11)));
      end
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (strobe_i) begin
      rdata_q <= req_i.we ? '0 : rdata_d;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* verilog/periph_ram.sv */
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module periph_ram import soc_pkg::*; (
  input  wire logic     clk_sys_i,
  input  wire bus_req_t req_i,
  input  wire logic     strobe_i,
  output dev_rsp_t      rsp_o
);

  localparam int RAM_AW = $clog2(`SOC_RAM_WORDS);

  data_t             mem [`SOC_RAM_WORDS];
  logic [RAM_AW-1:0] idx;
  logic              rvalid_q;
  data_t             rdata_q;

  // Word index without the byte offset.
  assign idx = req_i.addr[RAM_AW+1:2];

  always_ff @(posedge clk_sys_i) begin
    rvalid_q <= strobe_i;
    if (strobe_i) begin
      if (req_i.we) begin
        for (int i = 0; i < `SOC_BE_W; i++) begin
          if (req_i.be[i]) begin
            mem[idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* verilog/bus_host_port.sv */
`timescale 1ns/100ps
`default_nettype none

`include "soc_params.svh"

module bus_host_port import soc_pkg::*; (
  input  wire logic        clk_sys_i,
  input  wire logic        rst_n_i,
  input  wire logic        req_valid_i,
  output logic             req_ready_o,
  input  wire bus_req_t    req_i,
  output bus_req_t         dev_req_o,
  output dev_strobe_t      dev_strobe_o,
  output logic             decode_err_o,
  input  wire logic        rsp_done_i
);

  port_state_e state_q;
  port_state_e state_d;
  dev_strobe_t strobe_d;
  logic        accept;

  // Only one access in flight.
  assign req_ready_o = (state_q == ST_IDLE);
  assign accept      = req_valid_i & req_ready_o;

  ////////////////////
  // Address decode
  ////////////////////

  always_comb begin
    strobe_d       = '0;
    strobe_d.ram   = (req_i.addr & ~addr_t'(`SOC_RAM_MASK)) == addr_t'(`SOC_RAM_BASE);
    strobe_d.gpio  = (req_i.addr & ~addr_t'(`SOC_GPIO_MASK)) == addr_t'(`SOC_GPIO_BASE);
    strobe_d.timer = (req_i.addr & ~addr_t'(`SOC_TIMER_MASK)) == addr_t'(`SOC_TIMER_BASE);
    strobe_d.none  = ~(strobe_d.ram | strobe_d.gpio | strobe_d.timer);
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (accept) begin
          state_d = ST_ACCESS;
        end
      end
      ST_ACCESS: state_d = ST_WAIT;
      ST_WAIT: begin
        if (rsp_done_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_sys_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= ST_IDLE;
      dev_strobe_o <= '0;
      decode_err_o <= 1'b0;
    end else begin
      state_q      <= state_d;
      dev_strobe_o <= accept ? strobe_d : '0;
      // Unmapped access answers in the device slot.
      decode_err_o <= dev_strobe_o.none;
    end
  end

  always_ff @(posedge clk_sys_i) begin
    if (accept) begin
      dev_req_o <= req_i;
    end
  end

endmodule

`default_nettype wire

/* verilog/soc_pkg.sv */
`default_nettype none

`include "soc_params.svh"

package soc_pkg;

  // Vector types.
  typedef logic [`SOC_ADDR_W-1:0] addr_t;
  typedef logic [`SOC_DATA_W-1:0] data_t;
  typedef logic [`SOC_BE_W-1:0]   be_t;
  typedef logic [`SOC_GPI_W-1:0]  gpi_t;
  typedef logic [`SOC_GPO_W-1:0]  gpo_t;

  // Request from the host side.
  typedef struct packed {
    addr_t addr;
    logic  we;
    be_t   be;
    data_t wdata;
  } bus_req_t;

  // Response channel payload.
  typedef struct packed {
    data_t rdata;
    logic  err;
  } bus_rsp_t;

  // What each device hands back.
  typedef struct packed {
    logic  rvalid;
    data_t rdata;
  } dev_rsp_t;

  // One-hot device select.
  typedef struct packed {
    logic ram;
    logic gpio;
    logic timer;
    logic none;
  } dev_strobe_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ACCESS,
    ST_WAIT
  } port_state_e;

  // Replace the enabled bytes of old_d with those of new_d.
  function automatic data_t be_merge(data_t old_d, data_t new_d, be_t be);
    data_t res;
    res = old_d;
    for (int i = 0; i < `SOC_BE_W; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_d[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

/* verilog/soc_params.svh */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths.
`define SOC_ADDR_W 32
`define SOC_DATA_W 32
`define SOC_BE_W 4

// RAM depth in words.
`define SOC_RAM_WORDS 256

// GPIO widths.
`define SOC_GPI_W 8
`define SOC_GPO_W 16

// Base address and mask of each device.
`define SOC_RAM_BASE 32'h0000_0000
`define SOC_RAM_MASK 32'h0000_03FF
`define SOC_GPIO_BASE 32'h8000_0000
`define SOC_GPIO_MASK 32'h0000_00FF
`define SOC_TIMER_BASE 32'h8000_1000
`define SOC_TIMER_MASK 32'h0000_00FF

// Register offsets inside a device window.
`define SOC_GPIO_OUT_OFS 32'h0
`define SOC_GPIO_IN_OFS 32'h4
`define SOC_TIMER_MTIME_OFS 32'h0
`define SOC_TIMER_CMP_OFS 32'h4

`endif
